// ==== test/read_stimulus.txt ====
// group master id addr len stall, all hex, one read per line
// lines that share a group number start together
0 0 3 00000100 3 0
1 1 a 00010000 0 0
2 0 5 0000fffc 7 1
3 1 e 0001fff0 f 1
4 0 1 00000200 2 0
4 1 2 00010400 4 0
5 0 7 00010800 1 1
5 1 9 00000300 5 1
6 1 0 00000000 0 0
7 0 f 00020000 f 0
7 1 c 0000fff0 3 0
8 0 4 00000400 0 1
8 1 6 00010010 6 1
9 1 b 00000500 2 0
a 0 d 00011000 4 1
a 1 8 00000600 1 0
b 0 2 0000ffff 1 0
c 1 1 00010001 2 1

// ==== src.f ====
source/axi_pkg.sv
source/axi_ar_if.sv
source/axi_r_if.sv
source/rr_arbiter.sv
source/ar_router.sv
source/r_router.sv
source/axi_read_xbar.sv
test/tb_clock.sv
test/tb_axi_read_xbar.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_axi_read_xbar
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_axi_read_xbar.sv ====
`timescale 1ns/100ps

module tb_axi_read_xbar;

	localparam logic [31:0] SEED        = 32'hc711e1d9;
	localparam logic [31:0] SLAVE1_BASE = 32'h0001_0000;
	localparam int          STIM_WORDS  = 64 * 6;
	localparam int          WAIT_LIMIT  = 200;
	localparam int          IDLE_LIMIT  = 4000;

	logic        ACLK;
	logic        ARESETn;
	logic [1:0]  grant;

	logic [3:0]  m_arid [2];
	logic [31:0] m_araddr [2];
	logic [3:0]  m_arlen [2];
	logic [2:0]  m_arsize [2];
	logic [1:0]  m_arburst [2];
	logic        m_arvalid [2];
	logic        m_arready [2];
	logic [3:0]  m_rid [2];
	logic [31:0] m_rdata [2];
	logic [1:0]  m_rresp [2];
	logic        m_rlast [2];
	logic        m_rvalid [2];
	logic        m_rready [2];

	logic [4:0]  s_arid [2];
	logic [31:0] s_araddr [2];
	logic [3:0]  s_arlen [2];
	logic [2:0]  s_arsize [2];
	logic [1:0]  s_arburst [2];
	logic        s_arvalid [2];
	logic        s_arready [2];
	logic [4:0]  s_rid [2];
	logic [31:0] s_rdata [2];
	logic [1:0]  s_rresp [2];
	logic        s_rlast [2];
	logic        s_rvalid [2];
	logic        s_rready [2];

	logic [31:0] stim [STIM_WORDS];

	// Grant tracking for the monitor
	logic [1:0]  exp_grant   = 2'b00;
	logic        pending     = 1'b0;
	logic        busy        = 1'b0;
	logic        ar_seen     = 1'b0;
	// Master 0 first out of reset
	logic        last_served = 1'b1;

	tb_clock u_tb_clock (
		.ACLK    (ACLK),
		.ARESETn (ARESETn)
	);

	axi_read_xbar u_axi_read_xbar (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.grant      (grant),
		.m0_arid    (m_arid[0]),    .m1_arid    (m_arid[1]),
		.m0_araddr  (m_araddr[0]),  .m1_araddr  (m_araddr[1]),
		.m0_arlen   (m_arlen[0]),   .m1_arlen   (m_arlen[1]),
		.m0_arsize  (m_arsize[0]),  .m1_arsize  (m_arsize[1]),
		.m0_arburst (m_arburst[0]), .m1_arburst (m_arburst[1]),
		.m0_arvalid (m_arvalid[0]), .m1_arvalid (m_arvalid[1]),
		.m0_arready (m_arready[0]), .m1_arready (m_arready[1]),
		.m0_rid     (m_rid[0]),     .m1_rid     (m_rid[1]),
		.m0_rdata   (m_rdata[0]),   .m1_rdata   (m_rdata[1]),
		.m0_rresp   (m_rresp[0]),   .m1_rresp   (m_rresp[1]),
		.m0_rlast   (m_rlast[0]),   .m1_rlast   (m_rlast[1]),
		.m0_rvalid  (m_rvalid[0]),  .m1_rvalid  (m_rvalid[1]),
		.m0_rready  (m_rready[0]),  .m1_rready  (m_rready[1]),
		.s0_arid    (s_arid[0]),    .s1_arid    (s_arid[1]),
		.s0_araddr  (s_araddr[0]),  .s1_araddr  (s_araddr[1]),
		.s0_arlen   (s_arlen[0]),   .s1_arlen   (s_arlen[1]),
		.s0_arsize  (s_arsize[0]),  .s1_arsize  (s_arsize[1]),
		.s0_arburst (s_arburst[0]), .s1_arburst (s_arburst[1]),
		.s0_arvalid (s_arvalid[0]), .s1_arvalid (s_arvalid[1]),
		.s0_arready (s_arready[0]), .s1_arready (s_arready[1]),
		.s0_rid     (s_rid[0]),     .s1_rid     (s_rid[1]),
		.s0_rdata   (s_rdata[0]),   .s1_rdata   (s_rdata[1]),
		.s0_rresp   (s_rresp[0]),   .s1_rresp   (s_rresp[1]),
		.s0_rlast   (s_rlast[0]),   .s1_rlast   (s_rlast[1]),
		.s0_rvalid  (s_rvalid[0]),  .s1_rvalid  (s_rvalid[1]),
		.s0_rready  (s_rready[0]),  .s1_rready  (s_rready[1])
	);

	// ==============================
	// Checks
	// ==============================
	task automatic report_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			report_error($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
				name, actual, expected));
	endtask

	task automatic wait_reset();
		int cnt;
		cnt = 0;
		while (ARESETn !== 1'b1) begin
			@(posedge ACLK);
			cnt++;
			if (cnt > 20)
				report_error("Timeout: reset was never released");
		end
	endtask

	// Slave-side request against the granted master's channel
	task automatic check_request(input int s);
		int m;
		m = s_arid[s][4];
		if (!busy || ar_seen)
			report_error($sformatf("Slave %0d saw an address outside the address phase", s));
		check_equal("granted master", m, exp_grant[1]);
		check_equal($sformatf("s%0d_arvalid", 1 - s), s_arvalid[1 - s], 1'b0);
		check_equal("decoded slave", s, m_araddr[m] >= SLAVE1_BASE);
		check_equal($sformatf("m%0d_arvalid", m), m_arvalid[m], 1'b1);
		check_equal($sformatf("s%0d_arid", s), s_arid[s][3:0], m_arid[m]);
		check_equal($sformatf("s%0d_araddr", s), s_araddr[s], m_araddr[m]);
		check_equal($sformatf("s%0d_arlen", s), s_arlen[s], m_arlen[m]);
		check_equal($sformatf("s%0d_arsize", s), s_arsize[s], m_arsize[m]);
		check_equal($sformatf("s%0d_arburst", s), s_arburst[s], m_arburst[m]);
		if (s_arready[s])
			ar_seen = 1'b1;
	endtask

	// Round-robin model and grant lock
	always @(negedge ACLK) begin
		if (ARESETn) begin
			if (pending) begin
				check_equal("grant", grant, exp_grant);
				pending = 1'b0;
				busy    = 1'b1;
				ar_seen = 1'b0;
			end else if (busy) begin
				check_equal("grant", grant, exp_grant);
			end else begin
				check_equal("grant", grant, 2'b00);
				if (m_arvalid[0] || m_arvalid[1]) begin
					if (m_arvalid[0] && m_arvalid[1])
						exp_grant = last_served ? 2'b01 : 2'b10;
					else
						exp_grant = m_arvalid[1] ? 2'b10 : 2'b01;
					last_served = exp_grant[1];
					pending     = 1'b1;
				end
			end
			for (int s = 0; s < 2; s++) begin
				if (s_arvalid[s])
					check_request(s);
			end
			for (int m = 0; m < 2; m++) begin
				if (m_rvalid[m] && m_rready[m] && m_rlast[m])
					busy = 1'b0;
			end
		end
	end

	// ==============================
	// Slave model
	// ==============================
	task automatic serve_slave(input int s);
		logic [4:0]  id;
		logic [31:0] addr;
		logic [3:0]  len;
		int          beat;
		int          cnt;
		bit          got;
		forever begin
			cnt = 0;
			do begin
				@(negedge ACLK);
				cnt++;
				if (cnt > IDLE_LIMIT)
					report_error($sformatf("Timeout: slave %0d saw no read request", s));
			end while (!s_arvalid[s]);
			repeat ($urandom_range(3, 0)) @(posedge ACLK);
			@(posedge ACLK);
			s_arready[s] <= 1'b1;
			@(negedge ACLK);
			id   = s_arid[s];
			addr = s_araddr[s];
			len  = s_arlen[s];
			@(posedge ACLK);
			s_arready[s] <= 1'b0;
			beat = 0;
			while (beat <= int'(len)) begin
				if ($urandom_range(3, 0) == 0) begin
					s_rvalid[s] <= 1'b0;
					@(posedge ACLK);
				end else begin
					s_rvalid[s] <= 1'b1;
					s_rid[s]    <= id;
					s_rdata[s]  <= addr + 32'(beat);
					s_rresp[s]  <= axi_pkg::RESP_OKAY;
					s_rlast[s]  <= (beat == int'(len));
					cnt = 0;
					do begin
						@(negedge ACLK);
						got = s_rready[s];
						@(posedge ACLK);
						cnt++;
						if (!got && cnt > WAIT_LIMIT)
							report_error($sformatf("Timeout: slave %0d got no RREADY", s));
					end while (!got);
					beat++;
				end
			end
			s_rvalid[s] <= 1'b0;
			s_rlast[s]  <= 1'b0;
		end
	endtask

	// ==============================
	// Master driver
	// ==============================
	task automatic run_read(input bit m, input logic [3:0] id, input logic [31:0] addr,
			input logic [3:0] len, input bit stall);
		int beat;
		int cnt;
		@(posedge ACLK);
		m_arid[m]    <= id;
		m_araddr[m]  <= addr;
		m_arlen[m]   <= len;
		m_arsize[m]  <= 3'($urandom_range(2, 0));
		m_arburst[m] <= 2'($urandom_range(1, 0));
		m_arvalid[m] <= 1'b1;
		cnt = 0;
		do begin
			@(negedge ACLK);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_error($sformatf("Timeout: master %0d got no ARREADY", m));
		end while (!m_arready[m]);
		@(posedge ACLK);
		m_arvalid[m] <= 1'b0;
		beat = 0;
		cnt  = 0;
		while (beat <= int'(len)) begin
			m_rready[m] <= stall ? 1'($urandom_range(1, 0)) : 1'b1;
			@(negedge ACLK);
			check_equal($sformatf("m%0d_rvalid", !m), m_rvalid[!m], 1'b0);
			if (m_rvalid[m] && m_rready[m]) begin
				check_equal($sformatf("m%0d_rid", m), m_rid[m], id);
				check_equal($sformatf("m%0d_rdata", m), m_rdata[m], addr + 32'(beat));
				check_equal($sformatf("m%0d_rresp", m), m_rresp[m], axi_pkg::RESP_OKAY);
				check_equal($sformatf("m%0d_rlast", m), m_rlast[m], beat == int'(len));
				beat++;
				cnt = 0;
			end else begin
				cnt++;
				if (cnt > WAIT_LIMIT)
					report_error($sformatf("Timeout: master %0d got no read data", m));
			end
			@(posedge ACLK);
		end
		m_rready[m] <= 1'b0;
	endtask

	task automatic run_entry(input int e);
		run_read(stim[e * 6 + 1][0], stim[e * 6 + 2][3:0], stim[e * 6 + 3],
			stim[e * 6 + 4][3:0], stim[e * 6 + 5][0]);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int          idx;
		logic [31:0] grp;
		void'($urandom(SEED));
		for (int i = 0; i < 2; i++) begin
			m_arid[i]    = '0;
			m_araddr[i]  = '0;
			m_arlen[i]   = '0;
			m_arsize[i]  = '0;
			m_arburst[i] = '0;
			m_arvalid[i] = 1'b0;
			m_rready[i]  = 1'b0;
			s_arready[i] = 1'b0;
			s_rid[i]     = '0;
			s_rdata[i]   = '0;
			s_rresp[i]   = '0;
			s_rlast[i]   = 1'b0;
			s_rvalid[i]  = 1'b0;
		end
		for (int i = 0; i < STIM_WORDS; i++)
			stim[i] = '1;
		$readmemh("test/read_stimulus.txt", stim);
		if (stim[0] === 32'hffff_ffff)
			report_error("The stimulus file is missing or empty");

		wait_reset();
		@(negedge ACLK);
		// Idle outputs after reset
		check_equal("grant", grant, 2'b00);
		for (int i = 0; i < 2; i++) begin
			check_equal($sformatf("m%0d_arready", i), m_arready[i], 1'b0);
			check_equal($sformatf("m%0d_rvalid", i), m_rvalid[i], 1'b0);
			check_equal($sformatf("s%0d_arvalid", i), s_arvalid[i], 1'b0);
			check_equal($sformatf("s%0d_rready", i), s_rready[i], 1'b0);
		end

		fork
			serve_slave(0);
			serve_slave(1);
		join_none

		idx = 0;
		while (stim[idx * 6] !== 32'hffff_ffff) begin
			grp = stim[idx * 6];
			if (stim[(idx + 1) * 6] === grp) begin
				fork
					run_entry(idx);
					run_entry(idx + 1);
				join
				idx = idx + 2;
			end else begin
				run_entry(idx);
				idx = idx + 1;
			end
		end
		@(negedge ACLK);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic ACLK,
	output logic ARESETn
);

	initial begin
		ACLK = 1'b0;
		forever #HALF_PERIOD ACLK = ~ACLK;
	end

	initial begin
		ARESETn = 1'b0;
		repeat (RESET_CYCLES) @(posedge ACLK);
		ARESETn <= 1'b1;
	end

endmodule

// ==== source/axi_read_xbar.sv ====
`timescale 1ns/100ps

module axi_read_xbar #(
	parameter logic [axi_pkg::ADDR_BITS-1:0] SLAVE1_BASE = 32'h0001_0000
) (
	input  logic                            ACLK,
	input  logic                            ARESETn,
	output logic [1:0]                      grant,

	// Masters
	input  logic [axi_pkg::ID_BITS-1:0]     m0_arid, m1_arid,
	input  logic [axi_pkg::ADDR_BITS-1:0]   m0_araddr, m1_araddr,
	input  logic [axi_pkg::LEN_BITS-1:0]    m0_arlen, m1_arlen,
	input  logic [axi_pkg::SIZE_BITS-1:0]   m0_arsize, m1_arsize,
	input  logic [axi_pkg::BURST_BITS-1:0]  m0_arburst, m1_arburst,
	input  logic                            m0_arvalid, m1_arvalid,
	output logic                            m0_arready, m1_arready,
	output logic [axi_pkg::ID_BITS-1:0]     m0_rid, m1_rid,
	output logic [axi_pkg::DATA_BITS-1:0]   m0_rdata, m1_rdata,
	output logic [1:0]                      m0_rresp, m1_rresp,
	output logic                            m0_rlast, m1_rlast,
	output logic                            m0_rvalid, m1_rvalid,
	input  logic                            m0_rready, m1_rready,

	// Slaves
	output logic [axi_pkg::IDS_BITS-1:0]    s0_arid, s1_arid,
	output logic [axi_pkg::ADDR_BITS-1:0]   s0_araddr, s1_araddr,
	output logic [axi_pkg::LEN_BITS-1:0]    s0_arlen, s1_arlen,
	output logic [axi_pkg::SIZE_BITS-1:0]   s0_arsize, s1_arsize,
	output logic [axi_pkg::BURST_BITS-1:0]  s0_arburst, s1_arburst,
	output logic                            s0_arvalid, s1_arvalid,
	input  logic                            s0_arready, s1_arready,
	input  logic [axi_pkg::IDS_BITS-1:0]    s0_rid, s1_rid,
	input  logic [axi_pkg::DATA_BITS-1:0]   s0_rdata, s1_rdata,
	input  logic [1:0]                      s0_rresp, s1_rresp,
	input  logic                            s0_rlast, s1_rlast,
	input  logic                            s0_rvalid, s1_rvalid,
	output logic                            s0_rready, s1_rready
);

	logic read_done;
	logic addr_phase;
	logic data_phase;

	axi_ar_if #(.ID_W(axi_pkg::ID_BITS))  m_ar [2] ();
	axi_r_if  #(.ID_W(axi_pkg::ID_BITS))  m_r [2] ();
	axi_ar_if #(.ID_W(axi_pkg::IDS_BITS)) s_ar [2] ();
	axi_r_if  #(.ID_W(axi_pkg::IDS_BITS)) s_r [2] ();

	// ==============================
	// Master 0
	// ==============================
	assign m_ar[0].id    = m0_arid;
	assign m_ar[0].addr  = m0_araddr;
	assign m_ar[0].len   = m0_arlen;
	assign m_ar[0].size  = m0_arsize;
	assign m_ar[0].burst = m0_arburst;
	assign m_ar[0].valid = m0_arvalid;
	assign m0_arready    = m_ar[0].ready;
	assign m0_rid        = m_r[0].id;
	assign m0_rdata      = m_r[0].data;
	assign m0_rresp      = m_r[0].resp;
	assign m0_rlast      = m_r[0].last;
	assign m0_rvalid     = m_r[0].valid;
	assign m_r[0].ready  = m0_rready;

	// Master 1
	assign m_ar[1].id    = m1_arid;
	assign m_ar[1].addr  = m1_araddr;
	assign m_ar[1].len   = m1_arlen;
	assign m_ar[1].size  = m1_arsize;
	assign m_ar[1].burst = m1_arburst;
	assign m_ar[1].valid = m1_arvalid;
	assign m1_arready    = m_ar[1].ready;
	assign m1_rid        = m_r[1].id;
	assign m1_rdata      = m_r[1].data;
	assign m1_rresp      = m_r[1].resp;
	assign m1_rlast      = m_r[1].last;
	assign m1_rvalid     = m_r[1].valid;
	assign m_r[1].ready  = m1_rready;

	// ==============================
	// Slave 0
	// ==============================
	assign s0_arid       = s_ar[0].id;
	assign s0_araddr     = s_ar[0].addr;
	assign s0_arlen      = s_ar[0].len;
	assign s0_arsize     = s_ar[0].size;
	assign s0_arburst    = s_ar[0].burst;
	assign s0_arvalid    = s_ar[0].valid;
	assign s_ar[0].ready = s0_arready;
	assign s_r[0].id     = s0_rid;
	assign s_r[0].data   = s0_rdata;
	assign s_r[0].resp   = axi_pkg::resp_e'(s0_rresp);
	assign s_r[0].last   = s0_rlast;
	assign s_r[0].valid  = s0_rvalid;
	assign s0_rready     = s_r[0].ready;

	// Slave 1
	assign s1_arid       = s_ar[1].id;
	assign s1_araddr     = s_ar[1].addr;
	assign s1_arlen      = s_ar[1].len;
	assign s1_arsize     = s_ar[1].size;
	assign s1_arburst    = s_ar[1].burst;
	assign s1_arvalid    = s_ar[1].valid;
	assign s_ar[1].ready = s1_arready;
	assign s_r[1].id     = s1_rid;
	assign s_r[1].data   = s1_rdata;
	assign s_r[1].resp   = axi_pkg::resp_e'(s1_rresp);
	assign s_r[1].last   = s1_rlast;
	assign s_r[1].valid  = s1_rvalid;
	assign s1_rready     = s_r[1].ready;

	rr_arbiter u_rr_arbiter (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.m_ar       (m_ar),
		.read_done  (read_done),
		.grant      (grant),
		.addr_phase (addr_phase),
		.data_phase (data_phase)
	);

	ar_router #(
		.SLAVE1_BASE (SLAVE1_BASE)
	) u_ar_router (
		.grant      (grant),
		.addr_phase (addr_phase),
		.m_ar       (m_ar),
		.s_ar       (s_ar)
	);

	r_router u_r_router (
		.ACLK       (ACLK),
		.ARESETn    (ARESETn),
		.data_phase (data_phase),
		.s_r        (s_r),
		.m_r        (m_r),
		.read_done  (read_done)
	);

endmodule

// ==== source/r_router.sv ====
`timescale 1ns/100ps

module r_router (
	input  logic      ACLK,
	input  logic      ARESETn,
	input  logic      data_phase,
	axi_r_if.master   s_r [2],
	axi_r_if.slave    m_r [2],
	output logic      read_done
);

	logic [axi_pkg::IDS_BITS-1:0]  s_id [2];
	logic [axi_pkg::DATA_BITS-1:0] s_data [2];
	axi_pkg::resp_e                s_resp [2];
	logic [1:0]                    s_last;
	logic [1:0]                    s_valid;
	logic [1:0]                    s_ready;
	logic [1:0]                    m_valid;
	logic [1:0]                    m_ready;
	logic                          src;
	logic                          dst;
	logic                          fwd;
	logic                          beat;

	for (genvar i = 0; i < 2; i++) begin : g_slv
		assign s_id[i]      = s_r[i].id;
		assign s_data[i]    = s_r[i].data;
		assign s_resp[i]    = s_r[i].resp;
		assign s_last[i]    = s_r[i].last;
		assign s_valid[i]   = s_r[i].valid;
		assign s_r[i].ready = s_ready[i];
	end

	// ==============================
	// Source and destination
	// ==============================
	// Slave 0 wins if both are valid
	assign src  = ~s_valid[0];
	assign fwd  = data_phase & s_valid[src];
	assign dst  = s_id[src][axi_pkg::IDS_BITS-1];
	assign beat = fwd & m_ready[dst];

	assign m_valid   = {fwd & dst, fwd & ~dst};
	assign s_ready   = {2{fwd & m_ready[dst]}} & {src, ~src};
	assign read_done = beat & s_last[src];

	for (genvar k = 0; k < 2; k++) begin : g_mst
		assign m_r[k].valid = m_valid[k];
		// Top ID bit is stripped here
		assign m_r[k].id    = m_valid[k] ? s_id[src][axi_pkg::ID_BITS-1:0] : '0;
		assign m_r[k].data  = m_valid[k] ? s_data[src] : '0;
		assign m_r[k].resp  = m_valid[k] ? s_resp[src] : axi_pkg::RESP_OKAY;
		assign m_r[k].last  = m_valid[k] & s_last[src];
		assign m_ready[k]   = m_r[k].ready;
	end

	assert property (@(posedge ACLK) disable iff (!ARESETn) !(m_valid[0] && m_valid[1]))
		else $error("RVALID raised on both masters");

endmodule

// ==== source/ar_router.sv ====
`timescale 1ns/100ps

module ar_router #(
	parameter logic [axi_pkg::ADDR_BITS-1:0] SLAVE1_BASE = 32'h0001_0000
) (
	input  logic [1:0] grant,
	input  logic       addr_phase,
	axi_ar_if.slave    m_ar [2],
	axi_ar_if.master   s_ar [2]
);

	logic [axi_pkg::ID_BITS-1:0]    m_id [2];
	logic [axi_pkg::ADDR_BITS-1:0]  m_addr [2];
	logic [axi_pkg::LEN_BITS-1:0]   m_len [2];
	logic [axi_pkg::SIZE_BITS-1:0]  m_size [2];
	logic [axi_pkg::BURST_BITS-1:0] m_burst [2];
	logic [1:0]                     m_valid;
	logic [1:0]                     m_ready;
	logic [1:0]                     s_valid;
	logic [1:0]                     s_ready;
	logic                           sel;
	logic                           go;
	logic                           to_s1;

	for (genvar i = 0; i < 2; i++) begin : g_mst
		assign m_id[i]       = m_ar[i].id;
		assign m_addr[i]     = m_ar[i].addr;
		assign m_len[i]      = m_ar[i].len;
		assign m_size[i]     = m_ar[i].size;
		assign m_burst[i]    = m_ar[i].burst;
		assign m_valid[i]    = m_ar[i].valid;
		assign m_ar[i].ready = m_ready[i];
	end

	// ==============================
	// Master select and decode
	// ==============================
	assign sel   = grant[1];
	assign go    = addr_phase & m_valid[sel];
	assign to_s1 = (m_addr[sel] >= SLAVE1_BASE);

	assign s_valid = {go & to_s1, go & ~to_s1};

	// Ready back to the granted master only
	assign m_ready = {2{go & s_ready[to_s1]}} & grant;

	for (genvar j = 0; j < 2; j++) begin : g_slv
		assign s_ar[j].valid = s_valid[j];
		// Master index goes on top of the ID
		assign s_ar[j].id    = s_valid[j] ? {sel, m_id[sel]} : '0;
		assign s_ar[j].addr  = s_valid[j] ? m_addr[sel] : '0;
		assign s_ar[j].len   = s_valid[j] ? m_len[sel] : '0;
		assign s_ar[j].size  = s_valid[j] ? m_size[sel] : '0;
		assign s_ar[j].burst = s_valid[j] ? m_burst[sel] : '0;
		assign s_ready[j]    = s_ar[j].ready;
	end

	always_comb begin
		assert (!(s_valid[0] && s_valid[1]))
			else $error("ARVALID raised on both slaves");
	end

endmodule

// ==== source/rr_arbiter.sv ====
`timescale 1ns/100ps

module rr_arbiter (
	input  logic       ACLK,
	input  logic       ARESETn,
	axi_ar_if.monitor  m_ar [2],
	input  logic       read_done,
	output logic [1:0] grant,
	output logic       addr_phase,
	output logic       data_phase
);

	axi_pkg::arb_state_e state;
	logic [1:0]          req;
	logic [1:0]          ar_hs;
	logic                prio;
	logic                winner;
	logic                gidx;

	for (genvar i = 0; i < 2; i++) begin : g_mon
		assign req[i]   = m_ar[i].valid;
		assign ar_hs[i] = m_ar[i].valid & m_ar[i].ready;
	end

	// Tie goes to the priority master
	assign winner = (req[0] & req[1]) ? prio : req[1];
	assign gidx   = grant[1];

	// ==============================
	// Grant FSM
	// ==============================
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state <= axi_pkg::ARB_IDLE;
			grant <= 2'b00;
			prio  <= 1'b0;
		end else begin
			case (state)
				axi_pkg::ARB_IDLE: begin
					if (|req) begin
						state <= axi_pkg::ARB_ADDR;
						grant <= winner ? 2'b10 : 2'b01;
						// Other master first next time
						prio  <= ~winner;
					end
				end
				axi_pkg::ARB_ADDR: begin
					if (ar_hs[gidx]) begin
						state <= axi_pkg::ARB_DATA;
					end
				end
				axi_pkg::ARB_DATA: begin
					if (read_done) begin
						state <= axi_pkg::ARB_IDLE;
						grant <= 2'b00;
					end
				end
				default: begin
					state <= axi_pkg::ARB_IDLE;
					grant <= 2'b00;
				end
			endcase
		end
	end

	assign addr_phase = (state == axi_pkg::ARB_ADDR);
	assign data_phase = (state == axi_pkg::ARB_DATA);

	assert property (@(posedge ACLK) disable iff (!ARESETn) $onehot0(grant))
		else $error("grant is not zero or one-hot: %b", grant);

	// Locked from address phase until the last beat
	assert property (@(posedge ACLK) disable iff (!ARESETn)
		(state != axi_pkg::ARB_IDLE && !read_done) |=> $stable(grant))
		else $error("grant changed during a read");

endmodule

// ==== source/axi_r_if.sv ====
`timescale 1ns/100ps

interface axi_r_if #(
	parameter int ID_W = axi_pkg::ID_BITS
) ();

	logic [ID_W-1:0]                 id;
	logic [axi_pkg::DATA_BITS-1:0]   data;
	axi_pkg::resp_e                  resp;
	logic                            last;
	logic                            valid;
	logic                            ready;

	// Slave returns data
	modport slave (
		output id, data, resp, last, valid,
		input  ready
	);

	modport master (
		input  id, data, resp, last, valid,
		output ready
	);

endinterface

// ==== source/axi_ar_if.sv ====
`timescale 1ns/100ps

interface axi_ar_if #(
	parameter int ID_W = axi_pkg::ID_BITS
) ();

	logic [ID_W-1:0]                 id;
	logic [axi_pkg::ADDR_BITS-1:0]   addr;
	logic [axi_pkg::LEN_BITS-1:0]    len;
	logic [axi_pkg::SIZE_BITS-1:0]   size;
	logic [axi_pkg::BURST_BITS-1:0]  burst;
	logic                            valid;
	logic                            ready;

	modport master (
		output id, addr, len, size, burst, valid,
		input  ready
	);

	modport slave (
		input  id, addr, len, size, burst, valid,
		output ready
	);

	// Observe only, used by the arbiter
	modport monitor (
		input id, addr, len, size, burst, valid, ready
	);

endinterface

// ==== source/axi_pkg.sv ====
package axi_pkg;

	// ==============================
	// Channel widths
	// ==============================
	localparam int ID_BITS    = 4;
	// Slave side carries the master index on top
	localparam int IDS_BITS   = ID_BITS + 1;
	localparam int ADDR_BITS  = 32;
	localparam int DATA_BITS  = 32;
	localparam int LEN_BITS   = 4;
	localparam int SIZE_BITS  = 3;
	localparam int BURST_BITS = 2;

	// ==============================
	// Types
	// ==============================
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// Arbiter phases of one read
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_ADDR = 2'd1,
		ARB_DATA = 2'd2
	} arb_state_e;

endpackage
